// File: flist.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/oled_pkg.sv
rtl/reset_gen.sv
rtl/board_regs.sv
rtl/oled_spi.sv
rtl/board_top.sv
verification/tb_board_top.sv

// File: rtl/board_consts.svh
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// board pin counts
`define NUM_LEDS 8
`define NUM_BTNS 7

// cycles of clk_25mhz that the internal reset is held after rst_n rises
`define RESET_STRETCH 32

// clk_25mhz cycles per half period of oled_clk
`define SPI_DIV 2

// wishbone slave port
`define WB_DATA_W 16
`define WB_ADDR_W 2

`endif

// File: rtl/board_regs.sv
`include "board_consts.svh"
`default_nettype none

module board_regs (
  input  logic                   clk_25mhz,
  input  logic                   sys_rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`WB_ADDR_W-1:0]  wb_adr,
  input  logic [`WB_DATA_W-1:0]  wb_dat_w,
  output logic [`WB_DATA_W-1:0]  wb_dat_r,
  output logic                   wb_ack,
  input  logic [`NUM_BTNS-1:0]   btns,
  output logic [`NUM_LEDS-1:0]   leds,
  output logic                   oled_resn,
  output logic                   tx_start,
  output logic [7:0]             tx_byte,
  output oled_pkg::oled_mode_e   tx_mode,
  input  logic                   tx_busy
);

  bus_pkg::wb_state_e   state;
  bus_pkg::reg_addr_e   addr;
  logic                 req;
  logic                 tx_wr;
  logic [`NUM_BTNS-1:0] btn_meta;
  logic [`NUM_BTNS-1:0] btn_sync;
  logic [`WB_DATA_W-1:0] rd_data;

  assign addr   = bus_pkg::reg_addr_e'(wb_adr);
  assign req    = wb_cyc && wb_stb;
  assign tx_wr  = req && wb_we && (addr == bus_pkg::REG_OLED_TX);
  assign wb_ack = (state == bus_pkg::WB_ACK);

  // two flop synchronizer for the buttons
  always_ff @(posedge clk_25mhz) begin
    btn_meta <= btns;
    btn_sync <= btn_meta;
  end

  always_comb begin
    rd_data = '0;
    case (addr)
      bus_pkg::REG_LED:       rd_data[`NUM_LEDS-1:0] = leds;
      bus_pkg::REG_BTN:       rd_data[`NUM_BTNS-1:0] = btn_sync;
      bus_pkg::REG_OLED_CTRL: rd_data[0] = oled_resn;
      bus_pkg::REG_OLED_TX:   rd_data[0] = tx_busy;
      default:                rd_data = '0;
    endcase
  end

  // read data and transmit byte are captured when the request is taken
  always_ff @(posedge clk_25mhz) begin
    if (state == bus_pkg::WB_IDLE && req) begin
      wb_dat_r <= rd_data;
    end
    if (state == bus_pkg::WB_IDLE && tx_wr) begin
      tx_byte <= wb_dat_w[7:0];
      tx_mode <= oled_pkg::oled_mode_e'(wb_dat_w[8]);
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (!sys_rst_n) begin
      state     <= bus_pkg::WB_IDLE;
      leds      <= '0;
      oled_resn <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        bus_pkg::WB_IDLE: begin
          if (tx_wr && tx_busy) begin
            state <= bus_pkg::WB_WAIT_TX;
          end else if (req) begin
            state <= bus_pkg::WB_ACK;
            if (wb_we) begin
              case (addr)
                bus_pkg::REG_LED:       leds      <= wb_dat_w[`NUM_LEDS-1:0];
                bus_pkg::REG_OLED_CTRL: oled_resn <= wb_dat_w[0];
                bus_pkg::REG_OLED_TX:   tx_start  <= 1'b1;
                default:                ;
              endcase
            end
          end
        end
        // hold the ack until the previous byte has left
        bus_pkg::WB_WAIT_TX: begin
          if (!tx_busy) begin
            state    <= bus_pkg::WB_ACK;
            tx_start <= 1'b1;
          end
        end
        bus_pkg::WB_ACK: state <= bus_pkg::WB_IDLE;
        default:         state <= bus_pkg::WB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/board_top.sv
`include "board_consts.svh"
`default_nettype none

module board_top (
  input  logic                  clk_25mhz,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`WB_ADDR_W-1:0] wb_adr,
  input  logic [`WB_DATA_W-1:0] wb_dat_w,
  output logic [`WB_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  input  logic [`NUM_BTNS-1:0]  btns,
  output logic [`NUM_LEDS-1:0]  leds,
  output logic                  oled_clk,
  output logic                  oled_mosi,
  output logic                  oled_dc,
  output logic                  oled_resn,
  output logic                  oled_csn
);

  logic                 sys_rst_n;
  logic                 tx_start;
  logic [7:0]           tx_byte;
  oled_pkg::oled_mode_e tx_mode;
  logic                 tx_busy;

  reset_gen u_reset_gen (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .sys_rst_n (sys_rst_n)
  );

  board_regs u_board_regs (
    .clk_25mhz (clk_25mhz),
    .sys_rst_n (sys_rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .btns      (btns),
    .leds      (leds),
    .oled_resn (oled_resn),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_mode   (tx_mode),
    .tx_busy   (tx_busy)
  );

  oled_spi u_oled_spi (
    .clk_25mhz (clk_25mhz),
    .sys_rst_n (sys_rst_n),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_mode   (tx_mode),
    .tx_busy   (tx_busy),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_csn  (oled_csn)
  );

endmodule

`default_nettype wire

// File: rtl/bus_pkg.sv
`include "board_consts.svh"
`default_nettype none

package bus_pkg;

  // word addresses of the register map
  typedef enum logic [`WB_ADDR_W-1:0] {
    REG_LED       = 0,
    REG_BTN       = 1,
    REG_OLED_CTRL = 2,
    REG_OLED_TX   = 3
  } reg_addr_e;

  // wait state covers a transmit write while the engine is busy
  typedef enum logic [1:0] {
    WB_IDLE,
    WB_WAIT_TX,
    WB_ACK
  } wb_state_e;

endpackage

`default_nettype wire

// File: rtl/oled_pkg.sv
`default_nettype none

package oled_pkg;

  // byte serializer states
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_e;

  // level driven on oled_dc during a byte
  typedef enum logic {
    OLED_CMD  = 1'b0,
    OLED_DATA = 1'b1
  } oled_mode_e;

endpackage

`default_nettype wire

// File: rtl/oled_spi.sv
`include "board_consts.svh"
`default_nettype none

module oled_spi (
  input  logic                 clk_25mhz,
  input  logic                 sys_rst_n,
  input  logic                 tx_start,
  input  logic [7:0]           tx_byte,
  input  oled_pkg::oled_mode_e tx_mode,
  output logic                 tx_busy,
  output logic                 oled_clk,
  output logic                 oled_mosi,
  output logic                 oled_dc,
  output logic                 oled_csn
);

  localparam int DIV_W = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_DIV - 1);

  oled_pkg::spi_state_e state;
  logic [DIV_W-1:0]     div_cnt;
  logic [2:0]           bit_cnt;
  logic [7:0]           shift_q;
  logic                 div_end;
  logic                 clk_fall;

  assign div_end  = (div_cnt == DIV_LAST);
  assign clk_fall = (state == oled_pkg::SPI_SHIFT) && div_end && oled_clk;
  assign tx_busy  = (state != oled_pkg::SPI_IDLE);

  // byte in flight, msb leaves first
  always_ff @(posedge clk_25mhz) begin
    if (state == oled_pkg::SPI_IDLE && tx_start) begin
      shift_q <= tx_byte;
    end else if (clk_fall) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (!sys_rst_n) begin
      state     <= oled_pkg::SPI_IDLE;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      oled_clk  <= 1'b0;
      oled_mosi <= 1'b0;
      oled_dc   <= 1'b0;
      oled_csn  <= 1'b1;
    end else begin
      case (state)
        oled_pkg::SPI_IDLE: begin
          if (tx_start) begin
            state     <= oled_pkg::SPI_SHIFT;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            oled_csn  <= 1'b0;
            oled_dc   <= tx_mode;
            oled_mosi <= tx_byte[7];
          end
        end
        // mode 0: data changes on the falling edge, sampled on the rising one
        oled_pkg::SPI_SHIFT: begin
          if (div_end) begin
            div_cnt <= '0;
            if (!oled_clk) begin
              oled_clk <= 1'b1;
            end else begin
              oled_clk <= 1'b0;
              if (bit_cnt == 3'd7) begin
                state <= oled_pkg::SPI_DONE;
              end else begin
                bit_cnt   <= bit_cnt + 3'd1;
                oled_mosi <= shift_q[6];
              end
            end
          end else begin
            div_cnt <= div_cnt + DIV_W'(1);
          end
        end
        // one half period of hold before chip select goes away
        oled_pkg::SPI_DONE: begin
          if (div_end) begin
            state     <= oled_pkg::SPI_IDLE;
            div_cnt   <= '0;
            oled_csn  <= 1'b1;
            oled_mosi <= 1'b0;
          end else begin
            div_cnt <= div_cnt + DIV_W'(1);
          end
        end
        default: state <= oled_pkg::SPI_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/reset_gen.sv
`include "board_consts.svh"
`default_nettype none

module reset_gen (
  input  logic clk_25mhz,
  input  logic rst_n,
  output logic sys_rst_n
);

  logic [`RESET_STRETCH-1:0] stretch_q;

  // ones drain out of the low end once rst_n is high
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      stretch_q <= '1;
    end else begin
      stretch_q <= stretch_q >> 1;
    end
  end

  assign sys_rst_n = ~stretch_q[0];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the board_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_board_top -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_board_top)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: verification/tb_board_top.sv
`include "board_consts.svh"
`default_nettype none

module tb_board_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                  clk_25mhz;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`WB_ADDR_W-1:0] wb_adr;
  logic [`WB_DATA_W-1:0] wb_dat_w;
  logic [`WB_DATA_W-1:0] wb_dat_r;
  logic                  wb_ack;
  logic [`NUM_BTNS-1:0]  btns;
  logic [`NUM_LEDS-1:0]  leds;
  logic                  oled_clk;
  logic                  oled_mosi;
  logic                  oled_dc;
  logic                  oled_resn;
  logic                  oled_csn;

  int                   checks = 0;
  int                   value_errs = 0;
  int                   other_errs = 0;
  int                   cycle_cnt = 0;
  int                   mon_bits = 0;
  int                   csn_rises = 0;
  logic [7:0]           mon_byte;
  logic [8:0]           frames[$];
  logic [`NUM_LEDS-1:0] ack_leds;
  logic                 ack_resn;
  logic                 ack_csn;
  logic                 req_csn;

  board_top dut (.*);

  always #20 clk_25mhz = ~clk_25mhz;

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      value_errs++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      other_errs++;
      $display("error: %s", what);
    end
  endtask

  task automatic check_reset_outputs();
    compare("leds", 16'(leds), 16'h0000);
    compare("oled_csn", 16'(oled_csn), 16'h0001);
    compare("oled_clk", 16'(oled_clk), 16'h0000);
    compare("oled_mosi", 16'(oled_mosi), 16'h0000);
    compare("oled_resn", 16'(oled_resn), 16'h0000);
    confirm(!wb_ack, "wb_ack raised while the board was in reset");
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic wb_write(input logic [`WB_ADDR_W-1:0] adr, input logic [15:0] data,
                          output int waits);
    waits = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = data;
    do begin
      @(negedge clk_25mhz);
      waits++;
    end while (!wb_ack);
    ack_leds = leds;
    ack_resn = oled_resn;
    ack_csn = oled_csn;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge clk_25mhz);
  endtask

  task automatic wb_read(input logic [`WB_ADDR_W-1:0] adr, output logic [15:0] data);
    int waits;
    waits = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    // busy flag is taken at the next edge, so it follows this chip select
    req_csn = oled_csn;
    do begin
      @(negedge clk_25mhz);
      waits++;
    end while (!wb_ack);
    data = wb_dat_r;
    confirm(waits == 1, "read ack did not come on the second rising edge");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge clk_25mhz);
  endtask

  task automatic wait_tx_idle();
    logic [15:0] rd;
    do begin
      wb_read(bus_pkg::REG_OLED_TX, rd);
      compare("wb_dat_r busy", rd, {15'h0000, ~req_csn});
    end while (rd[0]);
  endtask

  task automatic check_frame(input logic [7:0] b, input oled_pkg::oled_mode_e mode);
    logic [8:0] frame;
    confirm(frames.size() > 0, "an expected SPI frame never appeared");
    if (frames.size() > 0) begin
      frame = frames.pop_front();
      compare("oled_mosi byte", 16'(frame[7:0]), 16'(b));
      compare("oled_dc", 16'(frame[8]), 16'(mode));
    end
  endtask

  task automatic transmit_one(input oled_pkg::oled_mode_e mode);
    logic [7:0]  b;
    logic [15:0] rd;
    int          waits;
    b = 8'($urandom());
    frames.delete();
    wb_write(bus_pkg::REG_OLED_TX, {7'h00, mode, b}, waits);
    confirm(waits == 1, "transmit write to an idle engine was held off");
    wb_read(bus_pkg::REG_OLED_TX, rd);
    compare("wb_dat_r busy", rd, 16'h0001);
    wait_tx_idle();
    check_frame(b, mode);
    confirm(frames.size() == 0, "more than one SPI frame for a single write");
  endtask

  task automatic back_to_back();
    logic [7:0] b0;
    logic [7:0] b1;
    int         w0;
    int         w1;
    int         rises;
    b0 = 8'($urandom());
    b1 = 8'($urandom());
    frames.delete();
    wb_write(bus_pkg::REG_OLED_TX, {7'h00, oled_pkg::OLED_DATA, b0}, w0);
    confirm(w0 == 1, "first transmit write to an idle engine was held off");
    rises = csn_rises;
    wb_write(bus_pkg::REG_OLED_TX, {7'h00, oled_pkg::OLED_CMD, b1}, w1);
    confirm(w1 > 1, "second transmit write was not held off by the busy engine");
    confirm(csn_rises == rises + 1, "second transmit acked before the first frame ended");
    compare("oled_csn", 16'(ack_csn), 16'h0001);
    wait_tx_idle();
    check_frame(b0, oled_pkg::OLED_DATA);
    check_frame(b1, oled_pkg::OLED_CMD);
  endtask

  // spi monitor, mode 0 sampling on the rising clock
  always @(posedge oled_clk or posedge oled_csn) begin
    if (oled_csn) begin
      mon_bits = 0;
      csn_rises++;
    end else begin
      mon_byte = {mon_byte[6:0], oled_mosi};
      mon_bits++;
      if (mon_bits == 8) begin
        frames.push_back({oled_dc, mon_byte});
        mon_bits = 0;
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_25mhz);
      cycle_cnt++;
    end
    $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [15:0]          rd;
    logic [7:0]           led_val;
    logic [`NUM_BTNS-1:0] btn_val;
    int                   waits;
    void'($urandom(32'h7f2e));
    clk_25mhz = 1'b0;
    rst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    btns = '0;

    for (int i = 0; i < 8; i++) begin
      @(negedge clk_25mhz);
      if (i >= 2) begin
        check_reset_outputs();
      end
    end
    rst_n = 1'b1;
    // request held through the stretch, dropped before release
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_adr = bus_pkg::REG_LED;
    repeat (`RESET_STRETCH - 4) begin
      @(negedge clk_25mhz);
      check_reset_outputs();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    repeat (6) @(negedge clk_25mhz);
    check_reset_outputs();

    repeat (5) begin
      led_val = 8'($urandom());
      wb_write(bus_pkg::REG_LED, 16'(led_val), waits);
      confirm(waits == 1, "LED write ack did not come on the second rising edge");
      compare("leds", 16'(ack_leds), 16'(led_val));
      wb_read(bus_pkg::REG_LED, rd);
      compare("wb_dat_r leds", rd, 16'(led_val));
    end

    repeat (3) begin
      btn_val = `NUM_BTNS'($urandom());
      btns = btn_val;
      repeat (3) @(negedge clk_25mhz);
      wb_read(bus_pkg::REG_BTN, rd);
      compare("wb_dat_r btns", rd, 16'(btn_val));
    end

    wb_write(bus_pkg::REG_OLED_CTRL, 16'h0001, waits);
    compare("oled_resn", 16'(ack_resn), 16'h0001);
    wb_write(bus_pkg::REG_OLED_CTRL, 16'h0000, waits);
    compare("oled_resn", 16'(ack_resn), 16'h0000);

    transmit_one(oled_pkg::OLED_CMD);
    transmit_one(oled_pkg::OLED_DATA);
    back_to_back();

    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
